//--- hdl/bch_field_pkg.sv
// GF(2^m) arithmetic in polynomial basis
// elements are carried in MAX_M bits; callers keep the low m bits
package bch_field_pkg;

	localparam int MAX_M = 16;	// largest supported field

	typedef logic [MAX_M-1:0] elem_t;	// field element, low m bits used
	typedef logic [MAX_M:0]   fpoly_t;	// field polynomial incl. x^m term

	// *********************************************************************
	// field size and primitive polynomials
	// *********************************************************************

	// smallest m with 2^m-1 >= n
	function automatic int n2m(input int n);
		int m;
		m = 0;
		for (int i = 2; i <= MAX_M; i++) begin
			if (m == 0 && ((1 << i) - 1) >= n)
				m = i;
		end
		return m;
	endfunction

	// one primitive polynomial per field size
	function automatic fpoly_t field_poly(input int m);
		case (m)
			2:       return fpoly_t'('h7);		// x^2+x+1
			3:       return fpoly_t'('hb);		// x^3+x+1
			4:       return fpoly_t'('h13);	// x^4+x+1
			5:       return fpoly_t'('h25);	// x^5+x^2+1
			6:       return fpoly_t'('h43);	// x^6+x+1
			7:       return fpoly_t'('h83);	// x^7+x+1
			8:       return fpoly_t'('h11d);	// x^8+x^4+x^3+x^2+1
			9:       return fpoly_t'('h211);	// x^9+x^4+1
			10:      return fpoly_t'('h409);	// x^10+x^3+1
			11:      return fpoly_t'('h805);	// x^11+x^2+1
			12:      return fpoly_t'('h1053);
			13:      return fpoly_t'('h201b);
			14:      return fpoly_t'('h4443);
			15:      return fpoly_t'('h8003);	// x^15+x+1
			16:      return fpoly_t'('h1100b);
			default: return '0;		// unsupported size
		endcase
	endfunction

	// ones in the low m bits
	function automatic elem_t field_mask(input int m);
		return elem_t'((1 << m) - 1);
	endfunction

	// *********************************************************************
	// element operations
	// *********************************************************************

	// a * alpha, shift and reduce by the field polynomial
	function automatic elem_t mul1(input int m, input elem_t a);
		fpoly_t wide;
		wide = {1'b0, a} << 1;
		if (a[m-1])
			wide = wide ^ field_poly(m);	// x^m term cancels here
		return wide[MAX_M-1:0] & field_mask(m);
	endfunction

	// general product, msb first shift and add over b
	function automatic elem_t finite_mult(input int m, input elem_t a, input elem_t b);
		elem_t r;
		r = '0;
		for (int i = MAX_M - 1; i >= 0; i--) begin
			if (i < m) begin
				r = mul1(m, r);
				if (b[i])
					r = r ^ a;
			end
		end
		return r & field_mask(m);
	endfunction

	// alpha^p, exponent taken modulo the group order
	function automatic elem_t lpow(input int m, input int p);
		elem_t r;
		int e;
		e = p % ((1 << m) - 1);
		r = elem_t'(1);
		for (int i = 0; i < e; i++)
			r = mul1(m, r);
		return r;
	endfunction

endpackage

//--- hdl/bch_code_pkg.sv
// BCH code construction, evaluated at elaboration
package bch_code_pkg;

	localparam int MAX_N  = 1023;	// longest code, m up to 10
	localparam int MAX_NK = 512;	// widest parity

	typedef logic [MAX_NK-1:0] gen_t;	// generator without leading term

	// lcm of minimal polynomials of alpha^1 .. alpha^2t
	function automatic gen_t encoder_poly(input int n, input int k, input int t);
		int m;
		int nn;
		int a;
		int deg;
		logic [MAX_N-1:0] roots;
		bch_field_pkg::elem_t coef [MAX_NK+1];
		bch_field_pkg::elem_t root;
		gen_t g;
		m = bch_field_pkg::n2m(n);
		nn = (1 << m) - 1;
		roots = '0;
		for (int i = 0; i < t; i++) begin	// odd roots, even ones share cosets
			a = 2 * i + 1;
			for (int j = 0; j < m; j++) begin
				roots[a] = 1'b1;	// whole cyclotomic coset
				a = (2 * a) % nn;
			end
		end
		for (int i = 0; i <= MAX_NK; i++)
			coef[i] = '0;
		coef[0] = bch_field_pkg::elem_t'(1);
		deg = 0;
		for (int i = 0; i < nn; i++) begin
			if (roots[i]) begin	// multiply by (x + alpha^i)
				root = bch_field_pkg::lpow(m, i);
				for (int j = deg + 1; j > 0; j--)
					coef[j] = coef[j-1] ^ bch_field_pkg::finite_mult(m, coef[j], root);
				coef[0] = bch_field_pkg::finite_mult(m, coef[0], root);
				deg++;
			end
		end
		g = '0;
		for (int i = 0; i < n - k; i++)
			g[i] = (coef[i] != '0);	// coefficients end up binary
		return g;
	endfunction

	// counter state after a number of steps from restart
	function automatic bch_field_pkg::elem_t lfsr_count(input int m, input int steps);
		bch_field_pkg::fpoly_t p;
		bch_field_pkg::elem_t taps;
		bch_field_pkg::elem_t s;
		logic fb;
		p = bch_field_pkg::field_poly(m);
		taps = p[bch_field_pkg::MAX_M-1:0] & bch_field_pkg::field_mask(m);
		s = bch_field_pkg::elem_t'(1);	// restart value
		for (int i = 0; i < steps; i++) begin
			fb = ^(s & taps);
			s = (s >> 1) | (bch_field_pkg::elem_t'(fb) << (m - 1));	// same step as rtl
		end
		return s;
	endfunction

	// evaluation point of odd syndrome j
	function automatic bch_field_pkg::elem_t syn_root(input int m, input int j);
		return bch_field_pkg::lpow(m, 2 * j + 1);
	endfunction

endpackage

//--- hdl/lfsr_counter.sv
// frame position counter, fibonacci lfsr stepping every cycle
// sequence 1, lfsr_count(1), lfsr_count(2) ... period 2^M-1
module lfsr_counter #(
	parameter int M = 4	// state width
) (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         restart,	// reload state 1
	output logic [M-1:0] count	// current position code
);

	localparam bch_field_pkg::fpoly_t POLY = bch_field_pkg::field_poly(M);
	localparam logic [M-1:0] TAPS = POLY[M-1:0];	// x^m term dropped

	logic feedback;

	assign feedback = ^(count & TAPS);	// new top bit

	// *********************************************************************
	// state register
	// *********************************************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= M'(1);
		end else if (restart) begin
			count <= M'(1);	// position 0 next cycle
		end else begin
			count <= {feedback, count[M-1:1]};	// shift toward lsb
		end
	end

	// lock-up state of an xor lfsr is all zeros
	a_count_nonzero: assert property (
		@(posedge clk) disable iff (!arst_n)
		count != '0
	) else $error("lfsr_counter reached the all-zero state");

endmodule

//--- hdl/bch_encode.sv
// serial systematic bch encoder
// message bits pass straight through, then parity shifts out msb first
module bch_encode #(
	parameter int N = 15,	// codeword length
	parameter int K = 5,	// message length
	parameter int T = 3	// correctable errors
) (
	input  logic clk,
	input  logic arst_n,
	input  logic start,	// with message bit 0
	input  logic data_in,	// message bit stream
	output logic data_out,	// codeword bit stream
	output logic first,	// codeword bit 0 on data_out
	output logic penult,	// next cycle is last
	output logic last,	// codeword bit N-1 on data_out
	output logic busy	// codeword on data_out
);

	localparam int M  = bch_field_pkg::n2m(N);
	localparam int NK = N - K;	// parity length

	localparam bch_code_pkg::gen_t GEN_ALL = bch_code_pkg::encoder_poly(N, K, T);
	localparam logic [NK-1:0] GEN = GEN_ALL[NK-1:0];

	// counter codes, count holds lfsr_count(c-1) in cycle c
	localparam bch_field_pkg::elem_t LOAD_END_E = bch_code_pkg::lfsr_count(M, K - 2);
	localparam bch_field_pkg::elem_t PENULT_E   = bch_code_pkg::lfsr_count(M, N - 3);

	logic [M-1:0]  count;
	logic          load_lfsr;	// message bits 1..K-1 still coming
	logic [NK-1:0] lfsr;	// parity remainder
	logic          lfsr_in;
	logic          load_end;
	logic          penult_pos;

	lfsr_counter #(
		.M(M)
	) u_counter (
		.clk    (clk),
		.arst_n (arst_n),
		.restart(start),
		.count  (count)
	);

	assign load_end   = (count == LOAD_END_E[M-1:0]);	// cycle K-1
	assign penult_pos = (count == PENULT_E[M-1:0]);	// cycle N-2
	assign lfsr_in    = load_lfsr & (lfsr[NK-1] ^ data_in);	// division feedback

	// *********************************************************************
	// frame strobes
	// *********************************************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			first     <= 1'b0;
			penult    <= 1'b0;
			last      <= 1'b0;
			busy      <= 1'b0;
			load_lfsr <= 1'b0;
		end else begin
			first  <= start;
			penult <= !start && busy && penult_pos;
			last   <= !start && penult;	// a restart drops the old last

			// busy stops the wrapped counter from re-firing penult
			if (start)
				busy <= 1'b1;
			else if (last)
				busy <= 1'b0;

			if (start)
				load_lfsr <= 1'b1;
			else if (load_end)
				load_lfsr <= 1'b0;
		end
	end

	// *********************************************************************
	// parity lfsr and output bit
	// *********************************************************************

	always_ff @(posedge clk) begin
		if (start)
			lfsr <= {NK{data_in}} & GEN;	// empty register, feedback is bit 0
		else
			lfsr <= {lfsr[NK-2:0], 1'b0} ^ ({NK{lfsr_in}} & GEN);
		data_out <= (start || load_lfsr) ? data_in : lfsr[NK-1];	// message, then parity
	end

	a_last_after_penult: assert property (
		@(posedge clk) disable iff (!arst_n)
		last |-> $past(penult)
	) else $error("last without penult in the previous cycle");

	a_first_after_start: assert property (
		@(posedge clk) disable iff (!arst_n)
		first |-> $past(start)
	) else $error("first without start in the previous cycle");

	a_busy_ends_on_last: assert property (
		@(posedge clk) disable iff (!arst_n)
		$fell(busy) |-> $past(last)
	) else $error("busy fell without last");

endmodule

//--- hdl/bch_syndrome.sv
// serial odd syndrome unit, S1 S3 .. S(2T-1)
// horner evaluation of the received word at alpha^(2j+1)
module bch_syndrome #(
	parameter int N = 15,	// codeword length
	parameter int T = 3	// correctable errors
) (
	input  logic clk,
	input  logic arst_n,
	input  logic start,	// with received bit 0
	input  logic data_in,	// received bits, highest position first
	output logic done,	// one cycle after the final bit
	output logic error	// word not a codeword, held until next done
);

	localparam int M = bch_field_pkg::n2m(N);

	// count holds lfsr_count(c-1) in cycle c, final bit in cycle N-1
	localparam bch_field_pkg::elem_t FINAL_E = bch_code_pkg::lfsr_count(M, N - 2);

	logic [M-1:0]        count;
	logic                running;	// a word is being received
	logic                final_bit;
	logic [T-1:0][M-1:0] acc;	// syndrome accumulators
	wire  [T-1:0][M-1:0] acc_next;

	lfsr_counter #(
		.M(M)
	) u_counter (
		.clk    (clk),
		.arst_n (arst_n),
		.restart(start),
		.count  (count)
	);

	assign final_bit = running && !start && (count == FINAL_E[M-1:0]);

	// *********************************************************************
	// accumulators, acc = acc * alpha^(2j+1) + bit
	// *********************************************************************

	for (genvar j = 0; j < T; j++) begin : g_acc
		localparam bch_field_pkg::elem_t ROOT = bch_code_pkg::syn_root(M, j);

		bch_field_pkg::elem_t acc_ext;
		bch_field_pkg::elem_t prod;

		always_comb begin
			acc_ext        = '0;
			acc_ext[M-1:0] = acc[j];
			prod           = bch_field_pkg::finite_mult(M, acc_ext, ROOT);
		end

		assign acc_next[j] = start ? M'(data_in) : (prod[M-1:0] ^ M'(data_in));	// seed
	end

	always_ff @(posedge clk) begin
		acc <= acc_next;
	end

	// *********************************************************************
	// end of word
	// *********************************************************************

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			running <= 1'b0;
			done    <= 1'b0;
			error   <= 1'b0;
		end else begin
			done <= final_bit;
			if (start)
				running <= 1'b1;
			else if (final_bit)
				running <= 1'b0;	// counter wraps, keep done single
			if (final_bit)
				error <= |acc_next;	// includes the final bit
		end
	end

	a_done_single: assert property (
		@(posedge clk) disable iff (!arst_n)
		done |=> !done
	) else $error("done high in two consecutive cycles");

endmodule

//--- hdl/bch_codec.sv
// bch codec slice
// transmit side encodes a serial message, receive side flags bad words
module bch_codec #(
	parameter int N = 15,	// codeword length
	parameter int K = 5,	// message length
	parameter int T = 3	// correctable errors
) (
	input  logic clk,
	input  logic arst_n,

	// transmit path
	input  logic tx_start,	// with message bit 0
	input  logic tx_data,	// message bits
	output logic tx_data_out,	// codeword bits, one cycle later
	output logic tx_first,
	output logic tx_penult,
	output logic tx_last,
	output logic tx_busy,

	// receive path
	input  logic rx_start,	// with received bit 0
	input  logic rx_data,	// received bits
	output logic rx_done,	// cycle N
	output logic rx_error	// nonzero syndrome
);

	// *********************************************************************
	// encoder
	// *********************************************************************

	bch_encode #(
		.N(N),
		.K(K),
		.T(T)
	) u_encode (
		.clk     (clk),
		.arst_n  (arst_n),
		.start   (tx_start),
		.data_in (tx_data),
		.data_out(tx_data_out),
		.first   (tx_first),
		.penult  (tx_penult),
		.last    (tx_last),
		.busy    (tx_busy)
	);

	// syndrome check, independent of the transmit frame
	bch_syndrome #(
		.N(N),
		.T(T)
	) u_syndrome (
		.clk    (clk),
		.arst_n (arst_n),
		.start  (rx_start),
		.data_in(rx_data),
		.done   (rx_done),
		.error  (rx_error)
	);

endmodule

//--- test/bch_codec_vectors.svh
`ifndef BCH_CODEC_VECTORS_SVH
`define BCH_CODEC_VECTORS_SVH

// columns: message sent msb first, flip mask on the received word,
// expected rx_error, next start relative to cycle N (negative abandons)
typedef struct packed {
	logic [K-1:0] msg;
	logic [N-1:0] mask;
	logic         flag;
	int           gap;
} vec_t;

localparam int NUM_ROWS = 18;

localparam vec_t VECTORS [NUM_ROWS] = '{
	'{5'h00, 15'h0000, 1'b0, 2},	// zero word
	'{5'h1f, 15'h0000, 1'b0, 1},	// all ones message, start after last
	'{5'h01, 15'h0001, 1'b1, 1},	// weight 1, lowest position
	'{5'h10, 15'h4000, 1'b1, 0},	// weight 1, highest, start with last
	'{5'h0a, 15'h0101, 1'b1, 1},	// weight 2
	'{5'h15, 15'h0007, 1'b1, 0},	// weight 3, burst
	'{5'h13, 15'h1248, 1'b1, 1},	// weight 4
	'{5'h0c, 15'h7c00, 1'b1, 2},	// weight 5, burst in message part
	'{5'h1b, 15'h003f, 1'b1, 0},	// weight 6, burst in parity part
	'{5'h06, 15'h5403, 1'b1, 1},	// weight 5, spread
	'{5'h19, 15'h0537, 1'b0, 1},	// mask is a codeword, not seen
	'{5'h07, 15'h0000, 1'b0, -8},	// abandoned mid-word
	'{5'h1e, 15'h0800, 1'b1, -1},	// restart in the penult cycle
	'{5'h11, 15'h0000, 1'b0, -2},	// restart just before penult
	'{5'h0f, 15'h2000, 1'b1, -13},	// restart while still loading
	'{5'h14, 15'h0000, 1'b0, 1},
	'{5'h09, 15'h6000, 1'b1, 0},	// weight 2, adjacent
	'{5'h03, 15'h0421, 1'b1, 1}	// weight 3
};

`endif

//--- test/bch_codec_tb.sv
module bch_codec_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N  = 15;
	localparam int K  = 5;
	localparam int T  = 3;
	localparam int NK = N - K;
	localparam logic [NK:0] GEN_POLY = 11'h537;	// x^10+x^8+x^5+x^4+x^2+x+1

	`include "bch_codec_vectors.svh"

	localparam int NUM_RAND    = 8;	// random rows after the table
	localparam int NUM_ALL     = NUM_ROWS + NUM_RAND;
	localparam int MAX_CYC     = (NUM_ALL + 2) * 2 * N;
	localparam int WATCHDOG_NS = (NUM_ALL + 2) * 2 * N * 40;

	logic clk;
	logic arst_n;
	logic tx_start;
	logic tx_data;
	logic tx_data_out;
	logic tx_first;
	logic tx_penult;
	logic tx_last;
	logic tx_busy;
	logic rx_start;
	logic rx_data;
	logic rx_done;
	logic rx_error;

	logic [K-1:0] row_msg [NUM_ALL];
	logic [N-1:0] row_mask [NUM_ALL];
	logic         row_flag [NUM_ALL];
	int           row_gap [NUM_ALL];
	int           row_start [NUM_ALL];	// global cycle of each start

	// per cycle inputs and expected outputs
	logic [MAX_CYC-1:0] drv_tx_start;
	logic [MAX_CYC-1:0] drv_tx_data;
	logic [MAX_CYC-1:0] drv_rx_start;
	logic [MAX_CYC-1:0] drv_rx_data;
	logic [MAX_CYC-1:0] exp_data;
	logic [MAX_CYC-1:0] data_care;	// codeword bit expected
	logic [MAX_CYC-1:0] exp_first;
	logic [MAX_CYC-1:0] exp_penult;
	logic [MAX_CYC-1:0] exp_last;
	logic [MAX_CYC-1:0] exp_busy;
	logic [MAX_CYC-1:0] exp_done;
	logic [MAX_CYC-1:0] done_flag;	// word verdict at its done
	logic [MAX_CYC-1:0] exp_err;

	int total_cyc;
	int checks;
	int errors;

	bch_codec #(
		.N(N),
		.K(K),
		.T(T)
	) dut0 (
		.clk        (clk),
		.arst_n     (arst_n),
		.tx_start   (tx_start),
		.tx_data    (tx_data),
		.tx_data_out(tx_data_out),
		.tx_first   (tx_first),
		.tx_penult  (tx_penult),
		.tx_last    (tx_last),
		.tx_busy    (tx_busy),
		.rx_start   (rx_start),
		.rx_data    (rx_data),
		.rx_done    (rx_done),
		.rx_error   (rx_error)
	);

	always #20 clk = ~clk;	// 40 ns period

	// *********************************************************************
	// reference model
	// *********************************************************************

	// remainder of msg * x^(N-K) by msb first long division
	function automatic logic [NK-1:0] parity_of(input logic [K-1:0] msg);
		logic [N-1:0] r;
		r = {msg, {NK{1'b0}}};
		for (int i = N - 1; i >= NK; i--) begin
			if (r[i])
				r = r ^ (N'(GEN_POLY) << (i - NK));
		end
		return r[NK-1:0];
	endfunction

	task automatic load_rows();
		int w;
		int pos;
		for (int r = 0; r < NUM_ROWS; r++) begin
			row_msg[r]  = VECTORS[r].msg;
			row_mask[r] = VECTORS[r].mask;
			row_flag[r] = VECTORS[r].flag;
			row_gap[r]  = VECTORS[r].gap;
		end
		for (int r = NUM_ROWS; r < NUM_ALL; r++) begin
			row_msg[r]  = K'($urandom);
			row_mask[r] = '0;
			w = $urandom_range(2 * T, 0);	// within the code distance
			for (int i = 0; i < w; i++) begin
				pos = $urandom_range(N - 1, 0);
				while (row_mask[r][pos])
					pos = (pos + 1) % N;	// next free position
				row_mask[r][pos] = 1'b1;
			end
			row_flag[r] = (w != 0);
			row_gap[r]  = $urandom_range(2, 0);
		end
	endtask

	// a later start truncates the older word so ownership never overlaps
	task automatic build_schedule();
		logic [N-1:0] cw;
		logic [N-1:0] rx_word;
		int s;
		int limit;
		int cyc;
		logic err;
		s = N + 2;	// idle past a full counter period after reset
		for (int r = 0; r < NUM_ALL; r++) begin
			row_start[r] = s;
			s = s + N + row_gap[r];
		end
		total_cyc = row_start[NUM_ALL-1] + N + 4;
		for (int c = 0; c < MAX_CYC; c++) begin
			drv_tx_data[c] = 1'($urandom);	// junk where ignored
			drv_rx_data[c] = 1'($urandom);
		end
		drv_tx_start = '0;
		drv_rx_start = '0;
		exp_data     = '0;
		data_care    = '0;
		exp_first    = '0;
		exp_penult   = '0;
		exp_last     = '0;
		exp_busy     = '0;
		exp_done     = '0;
		done_flag    = '0;
		for (int r = 0; r < NUM_ALL; r++) begin
			cw      = {row_msg[r], parity_of(row_msg[r])};	// systematic
			rx_word = cw ^ row_mask[r];
			limit   = (r < NUM_ALL - 1) ? row_start[r+1] : total_cyc;
			for (int c = 0; c < N && row_start[r] + c < limit; c++) begin
				cyc = row_start[r] + c;
				drv_tx_start[cyc] = (c == 0);
				drv_rx_start[cyc] = (c == 0);
				if (c < K)
					drv_tx_data[cyc] = row_msg[r][K-1-c];
				drv_rx_data[cyc] = rx_word[N-1-c];	// highest position first
			end
			for (int c = 1; c <= N && row_start[r] + c <= limit; c++) begin
				cyc = row_start[r] + c;
				exp_data[cyc]   = cw[N-c];
				data_care[cyc]  = 1'b1;
				exp_first[cyc]  = (c == 1);
				exp_penult[cyc] = (c == N - 1);
				exp_last[cyc]   = (c == N);
				exp_busy[cyc]   = 1'b1;
				exp_done[cyc]   = (c == N);
				done_flag[cyc]  = row_flag[r];
			end
		end
		err = 1'b0;	// low out of reset and held from done to done
		for (int c = 0; c < MAX_CYC; c++) begin
			if (exp_done[c])
				err = done_flag[c];
			exp_err[c] = err;
		end
	endtask

	// *********************************************************************
	// checks
	// *********************************************************************

	task automatic check_bit(input string name, input logic got, input logic want,
		input int cyc);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("** Error: %s = %h, expected %h in cycle %0d", name, got, want, cyc);
		end
	endtask

	task automatic compare_outputs(input int c);
		if (data_care[c])
			check_bit("tx_data_out", tx_data_out, exp_data[c], c);
		check_bit("tx_first", tx_first, exp_first[c], c);
		check_bit("tx_penult", tx_penult, exp_penult[c], c);
		check_bit("tx_last", tx_last, exp_last[c], c);
		check_bit("tx_busy", tx_busy, exp_busy[c], c);
		check_bit("rx_done", rx_done, exp_done[c], c);
		check_bit("rx_error", rx_error, exp_err[c], c);
	endtask

	// *********************************************************************
	// run
	// *********************************************************************

	initial begin
		clk      = 1'b0;
		arst_n   = 1'b0;
		tx_start = 1'b0;
		tx_data  = 1'b0;
		rx_start = 1'b0;
		rx_data  = 1'b0;
		checks   = 0;
		errors   = 0;
		void'($urandom(24987));	// single seed for the whole run
		load_rows();
		build_schedule();
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
		for (int c = 0; c < total_cyc; c++) begin
			@(negedge clk);	// settled outputs checked before new inputs
			compare_outputs(c);
			tx_start = drv_tx_start[c];
			tx_data  = drv_tx_data[c];
			rx_start = drv_rx_start[c];
			rx_data  = drv_rx_data[c];
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired, the run did not end within %0d ns", WATCHDOG_NS);
		$display("checks %0d, errors %0d", checks, errors + 1);
		$display("Finished with errors");
		$finish;
	end

endmodule

//--- flist.f
hdl/bch_field_pkg.sv
hdl/bch_code_pkg.sv
hdl/lfsr_counter.sv
hdl/bch_encode.sv
hdl/bch_syndrome.sv
hdl/bch_codec.sv
+incdir+test
test/bch_codec_tb.sv

//--- Bender.yml
package:
  name: bch_codec

sources:
  - hdl/bch_field_pkg.sv
  - hdl/bch_code_pkg.sv
  - hdl/lfsr_counter.sv
  - hdl/bch_encode.sv
  - hdl/bch_syndrome.sv
  - hdl/bch_codec.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/bch_codec_tb.sv
